//--- include/gfx_defines.svh
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

// One registry slot per model
`define MAX_MODEL_COUNT 8

// Capacity of the model RAM in triangles
`define MAX_TRIANGLE_COUNT 64

// Signed vertex coordinate width
`define COORD_WIDTH 16

// One extra count value so that a full buffer differs from an empty one
`define TRI_COUNT_WIDTH ($clog2(`MAX_TRIANGLE_COUNT + 1))

`define MODEL_INDEX_WIDTH ($clog2(`MAX_MODEL_COUNT))

`endif

//--- verilog/geom_pkg.sv
`default_nettype none

`include "gfx_defines.svh"

package geom_pkg;

    // One vertex in model space
    typedef struct packed {
        logic signed [`COORD_WIDTH-1:0] x;
        logic signed [`COORD_WIDTH-1:0] y;
        logic signed [`COORD_WIDTH-1:0] z;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // Sideband that travels next to each triangle on the output stream
    typedef struct packed {
        logic last; // Final triangle of a model
    } triangle_meta_t;

endpackage

`default_nettype wire

//--- verilog/modelbuf_pkg.sv
`default_nettype none

package modelbuf_pkg;

    // Host write into the model buffer
    typedef struct packed {
        logic [7:0]          model_id;
        geom_pkg::triangle_t triangle;
    } modelbuf_write_t;

    // One triangle fetch from a stored model
    typedef struct packed {
        logic [7:0]  model_index;
        logic [15:0] triangle_index;
    } modelbuf_read_t;

    typedef struct packed {
        logic [7:0] model_id; // Model to draw
    } draw_req_t;

    // Lifetime of a registry slot
    typedef enum logic [1:0] {
        MODEL_EMPTY   = 2'd0,
        MODEL_WRITING = 2'd1,
        MODEL_WRITTEN = 2'd2
    } model_state_t;

    typedef enum logic {
        READER_IDLE  = 1'b0,
        READER_ISSUE = 1'b1
    } reader_state_t;

endpackage

`default_nettype wire

//--- verilog/bram.sv
`default_nettype none
`timescale 1ns/1ns

module bram #(
    parameter int ENTRY_COUNT = 64,
    parameter int DATA_WIDTH  = 144
) (
    input  wire logic                           clk,

    input  wire logic                           write_enable,
    input  wire logic [$clog2(ENTRY_COUNT)-1:0] write_address,
    input  wire logic [DATA_WIDTH-1:0]          write_data,

    input  wire logic                           read_enable,
    input  wire logic [$clog2(ENTRY_COUNT)-1:0] read_address,
    output logic      [DATA_WIDTH-1:0]          read_data
);

    logic [DATA_WIDTH-1:0] mem [ENTRY_COUNT];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_address] <= write_data;
        end
    end

    // Registered read port that holds its output between reads
    always_ff @(posedge clk) begin
        if (read_enable) begin
            read_data <= mem[read_address];
        end
    end

endmodule

`default_nettype wire

//--- verilog/model_buffer.sv
`default_nettype none
`timescale 1ns/1ns

`include "gfx_defines.svh"

module model_buffer (
    input  wire logic                          clk,
    input  wire logic                          rstn,

    input  wire logic                          write_in_valid,
    output logic                               write_in_ready,
    input  wire modelbuf_pkg::modelbuf_write_t write_in_data,

    input  wire logic                          read_in_valid,
    output logic                               read_in_ready,
    input  wire modelbuf_pkg::modelbuf_read_t  read_in_data,

    input  wire logic [7:0]                    size_query_model,
    output logic [`TRI_COUNT_WIDTH-1:0]        size_query_count,

    output logic                               read_out_valid,
    input  wire logic                          read_out_ready,
    output geom_pkg::triangle_t                read_out_data,
    output geom_pkg::triangle_meta_t           read_out_metadata
);

    localparam int CNT_W  = `TRI_COUNT_WIDTH;
    localparam int MID_W  = `MODEL_INDEX_WIDTH;
    localparam int ADDR_W = $clog2(`MAX_TRIANGLE_COUNT);
    localparam int TRI_W  = $bits(geom_pkg::triangle_t);

    // Where a model lives in the RAM and how far it got
    typedef struct packed {
        logic [CNT_W-1:0]           start;
        logic [CNT_W-1:0]           size;
        modelbuf_pkg::model_state_t state;
    } registry_entry_t;

    registry_entry_t registry [`MAX_MODEL_COUNT];

    // Write side
    logic [MID_W-1:0] write_model;
    registry_entry_t  write_entry;
    logic [MID_W-1:0] prev_model;   // Model of the last accepted write
    logic             prev_valid;
    logic             model_change;
    logic [CNT_W-1:0] next_free;    // First unused RAM entry
    logic [CNT_W-1:0] write_addr;
    logic             full;
    logic             write_accept;
    logic             write_en;

    // Read side
    logic [MID_W-1:0] read_model;
    logic [15:0]      read_index;
    logic [15:0]      read_size;
    logic [15:0]      read_addr;
    logic             read_accept;

    assign write_in_ready = 1'b1; // RAM writes never stall

    assign write_model  = write_in_data.model_id[MID_W-1:0];
    assign write_entry  = registry[write_model];
    assign write_accept = write_in_valid && write_in_ready;
    assign model_change = prev_valid && (write_model != prev_model);
    assign full         = next_free == CNT_W'(`MAX_TRIANGLE_COUNT);

    always_comb begin
        if (write_entry.state == modelbuf_pkg::MODEL_EMPTY) begin
            write_addr = next_free;  // First triangle opens a new region
        end else begin
            write_addr = write_entry.start + write_entry.size;
        end
    end

    // Written models are locked, and nothing goes in once the RAM is full
    assign write_en = write_accept && !full
                      && (write_entry.state != modelbuf_pkg::MODEL_WRITTEN);

    assign read_model    = read_in_data.model_index[MID_W-1:0];
    assign read_index    = read_in_data.triangle_index;
    assign read_size     = 16'(registry[read_model].size);
    assign read_addr     = 16'(registry[read_model].start) + read_index;
    assign read_in_ready = !read_out_valid || read_out_ready;
    assign read_accept   = read_in_valid && read_in_ready;

    assign size_query_count = registry[size_query_model[MID_W-1:0]].size;

    bram #(
        .ENTRY_COUNT (`MAX_TRIANGLE_COUNT),
        .DATA_WIDTH  (TRI_W)
    ) bram_inst (
        .clk           (clk),
        .write_enable  (write_en),
        .write_address (write_addr[ADDR_W-1:0]),
        .write_data    (write_in_data.triangle),
        .read_enable   (read_accept),
        .read_address  (read_addr[ADDR_W-1:0]),
        .read_data     (read_out_data)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            next_free      <= '0;
            prev_model     <= '0;
            prev_valid     <= 1'b0;
            read_out_valid <= 1'b0;
            for (int i = 0; i < `MAX_MODEL_COUNT; i++) begin
                registry[i].start <= '0;
                registry[i].size  <= '0;
                registry[i].state <= modelbuf_pkg::MODEL_EMPTY;
            end
        end else begin
            if (write_accept) begin
                // Moving on to another model closes the open one
                if (model_change
                        && registry[prev_model].state == modelbuf_pkg::MODEL_WRITING) begin
                    registry[prev_model].state <= modelbuf_pkg::MODEL_WRITTEN;
                end
                prev_model <= write_model;
                prev_valid <= 1'b1;
            end

            if (write_en) begin
                if (write_entry.state == modelbuf_pkg::MODEL_EMPTY) begin
                    registry[write_model].start <= next_free;
                    registry[write_model].state <= modelbuf_pkg::MODEL_WRITING;
                end
                registry[write_model].size <= write_entry.size + 1'b1;
                next_free                  <= write_addr + 1'b1;
            end

            if (read_accept) begin
                read_out_valid <= read_index < read_size; // Out of range gives no response
            end else if (read_out_ready) begin
                read_out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_accept) begin
            read_out_metadata.last <= (read_index + 16'd1) == read_size;
        end
    end

    // A stalled response keeps its payload until it is taken
    assert property (@(posedge clk) disable iff (!rstn)
        read_out_valid && !read_out_ready |=> read_out_valid
            && $stable(read_out_data) && $stable(read_out_metadata));

    // Allocation stops at the RAM capacity
    assert property (@(posedge clk) disable iff (!rstn)
        next_free <= CNT_W'(`MAX_TRIANGLE_COUNT));

endmodule

`default_nettype wire

//--- verilog/model_reader.sv
`default_nettype none
`timescale 1ns/1ns

`include "gfx_defines.svh"

module model_reader (
    input  wire logic                         clk,
    input  wire logic                         rstn,

    input  wire logic                         draw_in_valid,
    output logic                              draw_in_ready,
    input  wire modelbuf_pkg::draw_req_t      draw_in_data,

    output logic [7:0]                        size_query_model,
    input  wire logic [`TRI_COUNT_WIDTH-1:0]  size_query_count,

    output logic                              read_req_valid,
    input  wire logic                         read_req_ready,
    output modelbuf_pkg::modelbuf_read_t      read_req_data
);

    localparam int CNT_W = `TRI_COUNT_WIDTH;

    modelbuf_pkg::reader_state_t state;
    logic [7:0]       model_id;  // Model captured with the draw
    logic [CNT_W-1:0] count;     // Its size at that moment
    logic [CNT_W-1:0] index;     // Next triangle to request
    logic             req_accept;
    logic             issue_done;

    assign draw_in_ready    = state == modelbuf_pkg::READER_IDLE;
    assign size_query_model = draw_in_data.model_id; // Size is sampled on the accepting edge

    // An empty model issues nothing
    assign read_req_valid = (state == modelbuf_pkg::READER_ISSUE) && (count != '0);
    assign read_req_data  = '{model_index: model_id, triangle_index: 16'(index)};

    assign req_accept = read_req_valid && read_req_ready;
    assign issue_done = (count == '0) || (req_accept && ((index + 1'b1) == count));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= modelbuf_pkg::READER_IDLE;
            model_id <= '0;
            count    <= '0;
            index    <= '0;
        end else begin
            case (state)
                modelbuf_pkg::READER_IDLE: begin
                    if (draw_in_valid) begin
                        model_id <= draw_in_data.model_id;
                        count    <= size_query_count;
                        index    <= '0;
                        state    <= modelbuf_pkg::READER_ISSUE;
                    end
                end
                modelbuf_pkg::READER_ISSUE: begin
                    if (issue_done) begin
                        state <= modelbuf_pkg::READER_IDLE;
                    end else if (req_accept) begin
                        index <= index + 1'b1;
                    end
                end
                default: begin
                    state <= modelbuf_pkg::READER_IDLE;
                end
            endcase
        end
    end

    // Requests never run past the size captured with the draw
    assert property (@(posedge clk) disable iff (!rstn)
        read_req_valid |-> index < count);

endmodule

`default_nettype wire

//--- verilog/render_front.sv
`default_nettype none
`timescale 1ns/1ns

`include "gfx_defines.svh"

module render_front (
    input  wire logic                          clk,
    input  wire logic                          rstn,

    input  wire logic                          write_in_valid,
    output logic                               write_in_ready,
    input  wire modelbuf_pkg::modelbuf_write_t write_in_data,

    input  wire logic                          draw_in_valid,
    output logic                               draw_in_ready,
    input  wire modelbuf_pkg::draw_req_t       draw_in_data,

    output logic                               out_valid,
    input  wire logic                          out_ready,
    output geom_pkg::triangle_t                out_data,
    output geom_pkg::triangle_meta_t           out_meta
);

    // Reader to buffer request stream
    logic                               read_req_valid;
    logic                               read_req_ready;
    modelbuf_pkg::modelbuf_read_t       read_req_data;

    logic [7:0]                         size_query_model;
    logic [`TRI_COUNT_WIDTH-1:0]        size_query_count;

    model_reader model_reader_inst (
        .clk              (clk),
        .rstn             (rstn),
        .draw_in_valid    (draw_in_valid),
        .draw_in_ready    (draw_in_ready),
        .draw_in_data     (draw_in_data),
        .size_query_model (size_query_model),
        .size_query_count (size_query_count),
        .read_req_valid   (read_req_valid),
        .read_req_ready   (read_req_ready),
        .read_req_data    (read_req_data)
    );

    model_buffer model_buffer_inst (
        .clk               (clk),
        .rstn              (rstn),
        .write_in_valid    (write_in_valid),
        .write_in_ready    (write_in_ready),
        .write_in_data     (write_in_data),
        .read_in_valid     (read_req_valid),
        .read_in_ready     (read_req_ready),
        .read_in_data      (read_req_data),
        .size_query_model  (size_query_model),
        .size_query_count  (size_query_count),
        .read_out_valid    (out_valid),
        .read_out_ready    (out_ready),
        .read_out_data     (out_data),
        .read_out_metadata (out_meta)
    );

endmodule

`default_nettype wire

//--- tests/tb_render_front.sv
`default_nettype none
`timescale 1ns/1ns

`include "gfx_defines.svh"

module tb_render_front;

    localparam int CLK_PERIOD  = 40;
    localparam int MODELS      = `MAX_MODEL_COUNT;
    localparam int CAPACITY    = `MAX_TRIANGLE_COUNT;
    localparam int WRITE_LIMIT = 108; // Upper bound on writes over all tests
    localparam int DRAW_COUNT  = 37;
    localparam int WATCHDOG_NS = (WRITE_LIMIT + DRAW_COUNT * CAPACITY + 200) * CLK_PERIOD;
    localparam int DRAIN_LIMIT = 100; // Cycles without an output before the wait gives up

    logic                          clk;
    logic                          rstn;
    logic                          write_in_valid;
    logic                          write_in_ready;
    modelbuf_pkg::modelbuf_write_t write_in_data;
    logic                          draw_in_valid;
    logic                          draw_in_ready;
    modelbuf_pkg::draw_req_t       draw_in_data;
    logic                          out_valid;
    logic                          out_ready;
    geom_pkg::triangle_t           out_data;
    geom_pkg::triangle_meta_t      out_meta;

    integer seed       = 74947;
    integer ready_seed = 74947; // Own stream so back-pressure does not shift the stimulus

    // Reference model of the registry and RAM contents
    geom_pkg::triangle_t        ref_tris [MODELS][CAPACITY];
    int                         ref_size [MODELS];
    modelbuf_pkg::model_state_t ref_state [MODELS];
    int                         ref_next_free;
    int                         ref_prev;
    bit                         ref_prev_valid;

    geom_pkg::triangle_t exp_tri_q[$];
    logic                exp_last_q[$];

    int                  mismatch_count;
    int                  other_count;
    bit                  stall_mode;
    bit                  held;          // Output was stalled at the previous edge
    geom_pkg::triangle_t held_data;
    logic                held_last;

    render_front render_front_inst (
        .clk            (clk),
        .rstn           (rstn),
        .write_in_valid (write_in_valid),
        .write_in_ready (write_in_ready),
        .write_in_data  (write_in_data),
        .draw_in_valid  (draw_in_valid),
        .draw_in_ready  (draw_in_ready),
        .draw_in_data   (draw_in_data),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_data       (out_data),
        .out_meta       (out_meta)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Consumer ready about two cycles out of three when stalling
    always @(negedge clk) begin
        if (stall_mode) begin
            out_ready = ($random(ready_seed) % 3) != 0;
        end else begin
            out_ready = 1'b1;
        end
    end

    function automatic geom_pkg::triangle_t random_triangle();
        geom_pkg::triangle_t value;
        for (int i = 0; i < 9; i++) begin
            value[i*16 +: 16] = 16'($random(seed));
        end
        return value;
    endfunction

    // Placement, lock and full rules applied to one accepted write
    task automatic apply_write_to_model(int m, geom_pkg::triangle_t value);
        if (ref_prev_valid && m != ref_prev
                && ref_state[ref_prev] == modelbuf_pkg::MODEL_WRITING) begin
            ref_state[ref_prev] = modelbuf_pkg::MODEL_WRITTEN;
        end
        if (ref_next_free < CAPACITY && ref_state[m] != modelbuf_pkg::MODEL_WRITTEN) begin
            if (ref_state[m] == modelbuf_pkg::MODEL_EMPTY) begin
                ref_state[m] = modelbuf_pkg::MODEL_WRITING;
            end
            ref_tris[m][ref_size[m]] = value;
            ref_size[m]++;
            ref_next_free++;
        end
        ref_prev       = m;
        ref_prev_valid = 1'b1;
    endtask

    task automatic write_triangle(int m);
        geom_pkg::triangle_t value;
        value = random_triangle();
        @(negedge clk);
        write_in_valid         = 1'b1;
        write_in_data.model_id = 8'(m);
        write_in_data.triangle = value;
        @(posedge clk);
        while (!write_in_ready) begin
            @(posedge clk);
        end
        apply_write_to_model(m, value);
    endtask

    task automatic stop_writes();
        @(negedge clk);
        write_in_valid = 1'b0;
    endtask

    task automatic draw_model(int m);
        @(negedge clk);
        draw_in_valid         = 1'b1;
        draw_in_data.model_id = 8'(m);
        @(posedge clk);
        while (!draw_in_ready) begin
            @(posedge clk);
        end
        for (int i = 0; i < ref_size[m]; i++) begin // Stored triangles in write order
            exp_tri_q.push_back(ref_tris[m][i]);
            exp_last_q.push_back(i == ref_size[m] - 1);
        end
        @(negedge clk);
        draw_in_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        int idle_cycles;
        int last_size;
        idle_cycles = 0;
        last_size   = exp_tri_q.size();
        while ((exp_tri_q.size() != 0 || !draw_in_ready) && idle_cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            if (exp_tri_q.size() == last_size) begin
                idle_cycles++;
            end else begin
                idle_cycles = 0;
                last_size   = exp_tri_q.size();
            end
        end
        repeat (4) @(posedge clk); // Room for any stray response
    endtask

    always @(posedge clk) begin : monitor
        geom_pkg::triangle_t exp_tri;
        logic                exp_last;
        if (rstn) begin
            if (held) begin
                assert (out_valid) else begin
                    other_count++;
                    $display("Time %0t: out_valid dropped while the output was stalled", $time);
                end
                assert (out_data === held_data) else begin
                    mismatch_count++;
                    $display("MISMATCH time=%0t signal=out_data expected=%h actual=%h",
                             $time, held_data, out_data);
                end
                assert (out_meta.last === held_last) else begin
                    mismatch_count++;
                    $display("MISMATCH time=%0t signal=out_meta.last expected=%b actual=%b",
                             $time, held_last, out_meta.last);
                end
            end
            if (out_valid && out_ready) begin
                assert (exp_tri_q.size() != 0) else begin
                    other_count++;
                    $display("Time %0t: output triangle arrived when none was expected", $time);
                end
                if (exp_tri_q.size() != 0) begin
                    exp_tri  = exp_tri_q.pop_front();
                    exp_last = exp_last_q.pop_front();
                    assert (out_data === exp_tri) else begin
                        mismatch_count++;
                        $display("MISMATCH time=%0t signal=out_data expected=%h actual=%h",
                                 $time, exp_tri, out_data);
                    end
                    assert (out_meta.last === exp_last) else begin
                        mismatch_count++;
                        $display("MISMATCH time=%0t signal=out_meta.last expected=%b actual=%b",
                                 $time, exp_last, out_meta.last);
                    end
                end
            end
            held      = out_valid && !out_ready;
            held_data = out_data;
            held_last = out_meta.last;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin : stimulus
        int m;
        int size;
        rstn           = 1'b0;
        write_in_valid = 1'b0;
        write_in_data  = '0;
        draw_in_valid  = 1'b0;
        draw_in_data   = '0;
        out_ready      = 1'b1;
        stall_mode     = 1'b0;
        held           = 1'b0;
        mismatch_count = 0;
        other_count    = 0;
        ref_next_free  = 0;
        ref_prev       = 0;
        ref_prev_valid = 1'b0;
        for (int i = 0; i < MODELS; i++) begin
            ref_size[i]  = 0;
            ref_state[i] = modelbuf_pkg::MODEL_EMPTY;
        end
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        repeat (2) @(negedge clk);

        // Models 0 to 3 with random sizes stored back to back
        for (m = 0; m < 4; m++) begin
            size = 1 + ($unsigned($random(seed)) % 8);
            repeat (size) write_triangle(m);
        end
        stop_writes();
        for (m = 0; m < 4; m++) begin
            draw_model(m);
        end
        wait_for_drain();

        repeat (8) draw_model($unsigned($random(seed)) % 4); // Any order with repeats allowed
        wait_for_drain();

        // Late writes to models that are already locked
        repeat (4) write_triangle($unsigned($random(seed)) % 3);
        stop_writes();
        for (m = 0; m < 4; m++) begin
            draw_model(m);
        end
        wait_for_drain();

        // Fill the RAM so that model 4 is cut short and model 5 gets nothing
        repeat (CAPACITY) write_triangle(4);
        repeat (8) write_triangle(5);
        stop_writes();
        for (m = 0; m < 6; m++) begin
            draw_model(m);
        end
        wait_for_drain();

        stall_mode = 1'b1;
        repeat (12) draw_model($unsigned($random(seed)) % 5);
        wait_for_drain();
        stall_mode = 1'b0;

        // Reader comes back to idle after a never written model
        draw_model(7);
        @(posedge clk);
        @(negedge clk);
        assert (draw_in_ready) else begin
            other_count++;
            $display("Time %0t: draw_in_ready stayed low after drawing an empty model", $time);
        end
        draw_model(6);
        draw_model(2);
        wait_for_drain();

        assert (exp_tri_q.size() == 0) else begin
            other_count++;
            $display("%0d expected triangles never arrived", exp_tri_q.size());
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
verilog/geom_pkg.sv
verilog/modelbuf_pkg.sv
verilog/bram.sv
verilog/model_buffer.sv
verilog/model_reader.sv
verilog/render_front.sv
tests/tb_render_front.sv
